/* vlog.f */
design/mc_cmd_pkg.sv
design/mc_engine_pkg.sv
design/cmd_frame_reader.sv
design/cmd_sequencer.sv
design/tile_launcher.sv
design/master_control.sv
test/tb_clock_gen.sv
test/tb_master_control.sv

/* Bender.yml */
package:
  name: master_control

sources:
  - design/mc_cmd_pkg.sv
  - design/mc_engine_pkg.sv
  - design/cmd_frame_reader.sv
  - design/cmd_sequencer.sv
  - design/tile_launcher.sv
  - design/master_control.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_master_control.sv

/* test/tb_master_control.sv */
// Testbench for master_control with random frames, engine models, reference model and checks
module tb_master_control;

    localparam int NUM_TILES      = 16;
    localparam int NUM_FRAMES     = 200;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 200;
    localparam int DRIVE_DLY      = 4;
    localparam int WORDS          = mc_cmd_pkg::CMD_FRAME_WORDS;

    logic                              clk;
    logic                              reset_n;
    // DUT inputs
    logic                              cmd_valid;
    logic [mc_cmd_pkg::CMD_WORD_W-1:0] cmd_data;
    logic                              result_afull;
    logic                              fetch_ready;
    logic                              fetch_done;
    logic                              disp_ready;
    logic                              dc_idle;
    logic                              ce_idle;
    // DUT outputs
    logic                              cmd_ready;
    logic                              fetch_valid;
    mc_engine_pkg::fetch_req_t         fetch_req;
    logic                              disp_valid;
    mc_engine_pkg::disp_req_t          disp_req;
    mc_engine_pkg::tile_params_t       tile_params;
    logic [NUM_TILES-1:0]              tile_en;
    logic [NUM_TILES-1:0]              tile_start;

    // Stimulus frames and the ordered list of frames that must produce a request
    logic [31:0]                       rng;
    logic [mc_cmd_pkg::CMD_WORD_W-1:0] frames [NUM_FRAMES][WORDS];
    int                                req_q[$];

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(16)) u_clock (.o_clk(clk), .o_reset_n(reset_n));

    master_control #(.NUM_TILES(NUM_TILES)) UUT (
        .i_clk(clk), .i_reset_n(reset_n),
        .i_cmd_valid(cmd_valid), .i_cmd_data(cmd_data), .o_cmd_ready(cmd_ready),
        .i_result_afull(result_afull),
        .o_fetch_valid(fetch_valid), .o_fetch(fetch_req),
        .i_fetch_ready(fetch_ready), .i_fetch_done(fetch_done),
        .o_disp_valid(disp_valid), .o_disp(disp_req), .i_disp_ready(disp_ready),
        .i_dc_idle(dc_idle),
        .o_tile_params(tile_params), .o_tile_en(tile_en), .o_tile_start(tile_start),
        .i_ce_idle(ce_idle)
    );

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng = xorshift(rng);
        r   = rng;
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] exp_val,
                               input logic [127:0] act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                                name, exp_val, act_val));
        end
    endtask

    // Pop the next request in command order and confirm its opcode
    task automatic take_request(input logic [7:0] op, input string kind, output int idx);
        if (req_q.size() == 0) begin
            abort_run($sformatf("Unexpected %s transfer with no request pending", kind));
        end else begin
            idx = req_q.pop_front();
            if (frames[idx][0][7:0] != op) begin
                abort_run($sformatf("%s transfer out of command order at frame %0d", kind, idx));
            end
        end
    endtask

    // Random frames with weighted opcodes and a few unknown ones
    task automatic build_frames();
        logic [31:0] r;
        logic [31:0] hdr;
        logic [7:0]  op;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            draw_random(r);
            draw_random(hdr);
            case (r[3:0])
                4'd0, 4'd1, 4'd2:       op = mc_cmd_pkg::e_cmd_op_fetch;
                4'd3, 4'd4, 4'd5:       op = mc_cmd_pkg::e_cmd_op_disp;
                4'd6, 4'd7, 4'd8, 4'd9: op = mc_cmd_pkg::e_cmd_op_tile;
                4'd10, 4'd11:           op = mc_cmd_pkg::e_cmd_op_wait_disp;
                4'd12, 4'd13:           op = mc_cmd_pkg::e_cmd_op_wait_tile;
                // Never in the F0 to F4 range
                default:                op = {4'h1, r[7:4]};
            endcase
            frames[f][0] = {hdr[31:8], op};
            for (int w = 1; w < WORDS; w++) begin
                draw_random(frames[f][w]);
            end
            if (op == mc_cmd_pkg::e_cmd_op_fetch || op == mc_cmd_pkg::e_cmd_op_disp ||
                op == mc_cmd_pkg::e_cmd_op_tile) begin
                req_q.push_back(f);
            end
        end
    endtask

    // ==============================
    // Reference model from the payload layout rule
    // ==============================
    function automatic mc_engine_pkg::fetch_req_t expect_fetch(input int idx);
        mc_engine_pkg::fetch_req_t req;
        req.addr  = frames[idx][1];
        req.len   = frames[idx][2][15:0];
        req.right = frames[idx][3][0];
        return req;
    endfunction

    function automatic mc_engine_pkg::disp_req_t expect_disp(input int idx);
        mc_engine_pkg::disp_req_t req;
        req.vec_size  = frames[idx][1][7:0];
        req.count     = frames[idx][1][23:16];
        req.tile_addr = frames[idx][2][15:0];
        req.man_4b    = frames[idx][3][0];
        req.broadcast = frames[idx][3][1];
        req.right     = frames[idx][3][2];
        req.col_start = frames[idx][3][7:3];
        req.col_en    = frames[idx][3][31:8];
        return req;
    endfunction

    function automatic mc_engine_pkg::tile_req_t expect_tile(input int idx);
        mc_engine_pkg::tile_req_t req;
        req.params.right_addr     = frames[idx][1][15:0];
        req.params.left_addr      = frames[idx][1][31:16];
        req.params.vec_len        = frames[idx][2][7:0];
        req.params.right_len      = frames[idx][2][15:8];
        req.params.left_len       = frames[idx][2][23:16];
        req.params.main_loop_left = frames[idx][3][0];
        req.params.right_4b       = frames[idx][3][1];
        req.params.left_4b        = frames[idx][3][2];
        req.col_en                = frames[idx][3][31:8];
        return req;
    endfunction

    // ==============================
    // Stimulus and engine models
    // ==============================
    initial begin : drive_inputs
        logic [31:0] r;
        int          frame_pos;
        int          word_pos;
        int          done_cnt;
        int          dc_busy;
        int          ce_busy;
        logic        word_fire;
        logic        fetch_fire;
        logic        disp_fire;
        logic        start_seen;
        cmd_valid    = 1'b0;
        cmd_data     = '0;
        result_afull = 1'b0;
        fetch_ready  = 1'b0;
        fetch_done   = 1'b0;
        disp_ready   = 1'b0;
        dc_idle      = 1'b1;
        ce_idle      = 1'b1;
        frame_pos    = 0;
        word_pos     = 0;
        done_cnt     = 0;
        dc_busy      = 0;
        ce_busy      = 0;
        rng          = 32'h8ace_8011;
        build_frames();
        @(posedge reset_n);
        forever begin
            // Handshakes that complete at the coming edge
            @(negedge clk);
            word_fire  = cmd_valid & cmd_ready;
            fetch_fire = fetch_valid & fetch_ready;
            disp_fire  = disp_valid & disp_ready;
            start_seen = |tile_start;
            @(posedge clk);
            #DRIVE_DLY;
            draw_random(r);
            if (word_fire) begin
                if (word_pos == WORDS - 1) begin
                    word_pos  = 0;
                    frame_pos = frame_pos + 1;
                end else begin
                    word_pos = word_pos + 1;
                end
            end
            // Valid and data held until the word transfers
            if (frame_pos >= NUM_FRAMES) begin
                cmd_valid = 1'b0;
            end else if (!cmd_valid || word_fire) begin
                cmd_valid = (r[1:0] != 2'b00);
                cmd_data  = frames[frame_pos][word_pos];
            end
            result_afull = (r[4:2] == 3'd0);
            fetch_ready  = (r[6:5] != 2'b00);
            disp_ready   = (r[8:7] != 2'b00);
            // One-cycle done a few cycles after each load
            fetch_done = 1'b0;
            if (done_cnt != 0) begin
                done_cnt = done_cnt - 1;
                if (done_cnt == 0) fetch_done = 1'b1;
            end
            if (fetch_fire) done_cnt = 1 + r[11:9];
            // Dispatcher busy after a copy and compute engine busy after a start
            if (disp_fire) dc_busy = r[15:12];
            dc_idle = (dc_busy == 0);
            if (dc_busy != 0) dc_busy = dc_busy - 1;
            if (start_seen) ce_busy = r[19:16];
            ce_idle = (ce_busy == 0);
            if (ce_busy != 0) ce_busy = ce_busy - 1;
        end
    end

    // ==============================
    // Checks sampled at the falling edge
    // ==============================
    initial begin : check_outputs
        int                          cycles;
        int                          acc_idx;
        int                          idx;
        int                          launch_age;
        int                          words_in;
        logic                        frame_held;
        logic                        fetch_wait;
        logic                        barrier_dc;
        logic                        barrier_ce;
        logic                        have_params;
        logic                        finished;
        logic                        any_req;
        logic                        new_req;
        logic                        prev_fetch_valid;
        logic                        prev_fetch_ready;
        logic                        prev_disp_valid;
        logic                        prev_disp_ready;
        logic                        prev_tile_valid;
        logic                        prev_afull;
        logic [7:0]                  op;
        logic [NUM_TILES-1:0]        exp_start;
        logic [NUM_TILES-1:0]        pend_mask;
        logic [NUM_TILES-1:0]        cur_mask;
        mc_engine_pkg::tile_req_t    exp_tile;
        mc_engine_pkg::tile_params_t pend_params;
        mc_engine_pkg::tile_params_t cur_params;
        cycles           = 0;
        acc_idx          = 0;
        idx              = 0;
        launch_age       = 0;
        words_in         = 0;
        frame_held       = 1'b0;
        fetch_wait       = 1'b0;
        barrier_dc       = 1'b0;
        barrier_ce       = 1'b0;
        have_params      = 1'b0;
        finished         = 1'b0;
        prev_fetch_valid = 1'b0;
        prev_fetch_ready = 1'b0;
        prev_disp_valid  = 1'b0;
        prev_disp_ready  = 1'b0;
        prev_tile_valid  = 1'b0;
        prev_afull       = 1'b0;
        pend_mask        = '0;
        cur_mask         = '0;
        pend_params      = '0;
        cur_params       = '0;
        @(posedge reset_n);
        // State right after reset
        check_value("o_cmd_ready", 1, cmd_ready);
        check_value("o_fetch_valid", 0, fetch_valid);
        check_value("o_disp_valid", 0, disp_valid);
        check_value("o_tile_en", 0, tile_en);
        check_value("o_tile_start", 0, tile_start);
        while (!finished) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run("Timeout, the DUT stopped making progress with commands pending");
            end
            // Stream open whenever the reader holds no complete frame
            check_value("o_cmd_ready", !frame_held, cmd_ready);
            // Launch pipeline of an earlier tile transfer
            if (launch_age == 1) begin
                cur_params  = pend_params;
                have_params = 1'b1;
            end
            if (launch_age == 2) cur_mask = pend_mask;
            exp_start = (launch_age == 2) ? pend_mask : '0;
            check_value("o_tile_start", exp_start, tile_start);
            check_value("o_tile_en", cur_mask, tile_en);
            if (have_params) check_value("o_tile_params", cur_params, tile_params);
            if (launch_age != 0) launch_age = (launch_age == 1) ? 2 : 0;
            // Valid and data of the oldest pending frame held while waiting for ready
            if (prev_fetch_valid && !prev_fetch_ready) begin
                check_value("o_fetch_valid", 1, fetch_valid);
                if (req_q.size() != 0) check_value("o_fetch", expect_fetch(req_q[0]), fetch_req);
            end
            if (prev_disp_valid && !prev_disp_ready) begin
                check_value("o_disp_valid", 1, disp_valid);
                if (req_q.size() != 0) check_value("o_disp", expect_disp(req_q[0]), disp_req);
            end
            // Ordering against afull, fetch done and barriers
            any_req = fetch_valid | disp_valid | UUT.tile_valid;
            new_req = (fetch_valid & ~prev_fetch_valid) | (disp_valid & ~prev_disp_valid) |
                      (UUT.tile_valid & ~prev_tile_valid);
            if (new_req && prev_afull) begin
                abort_run("A new command started while the result side was almost full");
            end
            if (fetch_wait && any_req) begin
                abort_run("A request appeared before the earlier FETCH reported done");
            end
            if ((barrier_dc || barrier_ce) && (any_req || tile_start != '0)) begin
                abort_run("A request or start pulse passed a barrier while its engine was busy");
            end
            if (fetch_done) fetch_wait = 1'b0;
            if (barrier_dc && dc_idle) barrier_dc = 1'b0;
            if (barrier_ce && ce_idle) barrier_ce = 1'b0;
            // Transfers at the coming edge
            if (fetch_valid && fetch_ready) begin
                take_request(mc_cmd_pkg::e_cmd_op_fetch, "Fetch", idx);
                check_value("o_fetch", expect_fetch(idx), fetch_req);
                fetch_wait = 1'b1;
            end
            if (disp_valid && disp_ready) begin
                take_request(mc_cmd_pkg::e_cmd_op_disp, "Disp", idx);
                check_value("o_disp", expect_disp(idx), disp_req);
            end
            if (UUT.tile_valid && UUT.tile_ready) begin
                take_request(mc_cmd_pkg::e_cmd_op_tile, "Tile", idx);
                exp_tile    = expect_tile(idx);
                pend_params = exp_tile.params;
                pend_mask   = exp_tile.col_en[NUM_TILES-1:0];
                launch_age  = 1;
            end
            // Frames are taken in stream order
            if (UUT.frame_valid && UUT.frame_ready) begin
                op = frames[acc_idx][0][7:0];
                if (op == mc_cmd_pkg::e_cmd_op_wait_disp) barrier_dc = 1'b1;
                if (op == mc_cmd_pkg::e_cmd_op_wait_tile) barrier_ce = 1'b1;
                acc_idx = acc_idx + 1;
            end
            // Reader holds a frame from its fourth word until the sequencer takes it
            if (frame_held && UUT.frame_ready) frame_held = 1'b0;
            if (cmd_valid && cmd_ready) begin
                if (words_in == WORDS - 1) begin
                    words_in   = 0;
                    frame_held = 1'b1;
                end else begin
                    words_in = words_in + 1;
                end
            end
            prev_fetch_valid = fetch_valid;
            prev_fetch_ready = fetch_ready;
            prev_disp_valid  = disp_valid;
            prev_disp_ready  = disp_ready;
            prev_tile_valid  = UUT.tile_valid;
            prev_afull       = result_afull;
            finished = (acc_idx == NUM_FRAMES) && (req_q.size() == 0) && !fetch_wait &&
                       !barrier_dc && !barrier_ce && (launch_age == 0);
        end
        $display("Test OK");
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock and synchronous reset generator
module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_reset_n
);

    // Free running clock
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Reset low for a fixed number of edges, released just after an edge
    initial begin
        o_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_reset_n = 1'b1;
    end

endmodule

/* design/master_control.sv */
// Top level of the command processor: frame reader, sequencer and tile launcher
module master_control #(
    parameter int NUM_TILES = 24
) (
    input  logic                              i_clk,
    input  logic                              i_reset_n,
    // Command word stream
    input  logic                              i_cmd_valid,
    input  logic [mc_cmd_pkg::CMD_WORD_W-1:0] i_cmd_data,
    output logic                              o_cmd_ready,
    input  logic                              i_result_afull,
    // Dispatcher
    output logic                              o_fetch_valid,
    output mc_engine_pkg::fetch_req_t         o_fetch,
    input  logic                              i_fetch_ready,
    input  logic                              i_fetch_done,
    output logic                              o_disp_valid,
    output mc_engine_pkg::disp_req_t          o_disp,
    input  logic                              i_disp_ready,
    input  logic                              i_dc_idle,
    // Compute engine
    output mc_engine_pkg::tile_params_t       o_tile_params,
    output logic [NUM_TILES-1:0]              o_tile_en,
    output logic [NUM_TILES-1:0]              o_tile_start,
    input  logic                              i_ce_idle
);

    // Reader to sequencer
    logic                     frame_valid;
    logic                     frame_ready;
    mc_cmd_pkg::cmd_frame_t   frame;
    // Sequencer to launcher
    logic                     tile_valid;
    logic                     tile_ready;
    mc_engine_pkg::tile_req_t tile_req;

    cmd_frame_reader u_reader (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_cmd_valid(i_cmd_valid), .i_cmd_data(i_cmd_data), .o_cmd_ready(o_cmd_ready),
        .o_frame_valid(frame_valid), .o_frame(frame), .i_frame_ready(frame_ready)
    );

    cmd_sequencer u_sequencer (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_frame_valid(frame_valid), .i_frame(frame), .o_frame_ready(frame_ready),
        .i_result_afull(i_result_afull),
        .o_fetch_valid(o_fetch_valid), .o_fetch(o_fetch),
        .i_fetch_ready(i_fetch_ready), .i_fetch_done(i_fetch_done),
        .o_disp_valid(o_disp_valid), .o_disp(o_disp), .i_disp_ready(i_disp_ready),
        .o_tile_valid(tile_valid), .o_tile(tile_req), .i_tile_ready(tile_ready),
        .i_dc_idle(i_dc_idle), .i_ce_idle(i_ce_idle)
    );

    tile_launcher #(.NUM_TILES(NUM_TILES)) u_launcher (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_tile_valid(tile_valid), .i_tile(tile_req), .o_tile_ready(tile_ready),
        .o_tile_params(o_tile_params), .o_tile_en(o_tile_en), .o_tile_start(o_tile_start)
    );

endmodule

/* design/tile_launcher.sv */
// Tile launcher: parameter setup, then column enable mask and one-cycle start pulse
module tile_launcher #(
    parameter int NUM_TILES = 24
) (
    input  logic                        i_clk,
    input  logic                        i_reset_n,

    // Tile request in
    input  logic                        i_tile_valid,
    input  mc_engine_pkg::tile_req_t    i_tile,
    output logic                        o_tile_ready,

    // Compute engine side
    output mc_engine_pkg::tile_params_t o_tile_params,
    output logic [NUM_TILES-1:0]        o_tile_en,
    output logic [NUM_TILES-1:0]        o_tile_start
);

    logic                 launch_pend;
    logic                 tile_xfer;
    logic [NUM_TILES-1:0] mask_q;

    // Busy for the one setup cycle
    assign o_tile_ready = ~launch_pend;
    assign tile_xfer    = i_tile_valid & o_tile_ready;

    // ==============================
    // Step 1, parameters and mask
    // ==============================
    always_ff @(posedge i_clk) begin
        if (tile_xfer) begin
            o_tile_params <= i_tile.params;
            // Only the columns this build has
            mask_q        <= i_tile.col_en[NUM_TILES-1:0];
        end
    end

    // ==============================
    // Step 2, enable and start
    // ==============================
    always_ff @(posedge i_clk) begin
        if (~i_reset_n) begin
            launch_pend  <= 1'b0;
            o_tile_en    <= '0;
            o_tile_start <= '0;
        end else begin
            // Start is a single-cycle pulse by default
            o_tile_start <= '0;
            if (tile_xfer) begin
                launch_pend <= 1'b1;
            end else if (launch_pend) begin
                // Addresses have been stable for a cycle
                launch_pend  <= 1'b0;
                o_tile_en    <= mask_q;
                o_tile_start <= mask_q;
            end
        end
    end

endmodule

/* design/cmd_sequencer.sv */
// Command sequencer: opcode decode, request issue, fetch completion wait and barriers
module cmd_sequencer (
    input  logic                       i_clk,
    input  logic                       i_reset_n,
    // Frame in
    input  logic                       i_frame_valid,
    input  mc_cmd_pkg::cmd_frame_t     i_frame,
    output logic                       o_frame_ready,
    input  logic                       i_result_afull,
    // Dispatcher load
    output logic                       o_fetch_valid,
    output mc_engine_pkg::fetch_req_t  o_fetch,
    input  logic                       i_fetch_ready,
    input  logic                       i_fetch_done,
    // Dispatcher copy
    output logic                       o_disp_valid,
    output mc_engine_pkg::disp_req_t   o_disp,
    input  logic                       i_disp_ready,
    // Tile launch
    output logic                       o_tile_valid,
    output mc_engine_pkg::tile_req_t   o_tile,
    input  logic                       i_tile_ready,
    // Engine idle levels for barriers
    input  logic                       i_dc_idle,
    input  logic                       i_ce_idle
);

    typedef enum logic [2:0] {
        st_idle, st_issue_fetch, st_wait_fetch_done, st_issue_disp,
        st_issue_tile, st_barrier_disp, st_barrier_tile, st_complete
    } state_t;

    state_t                    state_q;
    state_t                    state_d;
    logic                      frame_xfer;
    mc_cmd_pkg::cmd_op_t       frame_op;
    mc_cmd_pkg::cmd_fetch_t    fetch_cmd;
    mc_cmd_pkg::cmd_disp_t     disp_cmd;
    mc_cmd_pkg::cmd_tile_t     tile_cmd;
    mc_engine_pkg::fetch_req_t fetch_d;
    mc_engine_pkg::disp_req_t  disp_d;
    mc_engine_pkg::tile_req_t  tile_d;

    // Accept only from idle and when the result side has room
    assign o_frame_ready = (state_q == st_idle) & ~i_result_afull;
    assign frame_xfer    = i_frame_valid & o_frame_ready;
    assign frame_op      = mc_cmd_pkg::cmd_op_t'(i_frame.header.opcode);

    // Same payload bits, three views
    assign fetch_cmd = i_frame.payload;
    assign disp_cmd  = i_frame.payload;
    assign tile_cmd  = i_frame.payload;

    // ==============================
    // Payload to request mapping
    // ==============================
    always_comb begin
        fetch_d.addr              = fetch_cmd.addr;
        fetch_d.len               = fetch_cmd.len;
        fetch_d.right             = fetch_cmd.right;
        disp_d.tile_addr          = disp_cmd.tile_addr;
        disp_d.count              = disp_cmd.count;
        disp_d.vec_size           = disp_cmd.vec_size;
        disp_d.man_4b             = disp_cmd.man_4b;
        disp_d.col_en             = disp_cmd.col_en;
        disp_d.col_start          = disp_cmd.col_start;
        disp_d.right              = disp_cmd.right;
        disp_d.broadcast          = disp_cmd.broadcast;
        tile_d.params.left_addr   = tile_cmd.left_addr;
        tile_d.params.right_addr  = tile_cmd.right_addr;
        tile_d.params.left_len    = tile_cmd.left_len;
        tile_d.params.right_len   = tile_cmd.right_len;
        tile_d.params.vec_len     = tile_cmd.vec_len;
        tile_d.params.main_loop_left = tile_cmd.main_loop_left;
        tile_d.params.right_4b    = tile_cmd.right_4b;
        tile_d.params.left_4b     = tile_cmd.left_4b;
        tile_d.col_en             = tile_cmd.col_en;
    end

    // ==============================
    // FSM
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (frame_xfer) begin
                    case (frame_op)
                        mc_cmd_pkg::e_cmd_op_fetch:     state_d = st_issue_fetch;
                        mc_cmd_pkg::e_cmd_op_disp:      state_d = st_issue_disp;
                        mc_cmd_pkg::e_cmd_op_tile:      state_d = st_issue_tile;
                        mc_cmd_pkg::e_cmd_op_wait_disp: state_d = st_barrier_disp;
                        mc_cmd_pkg::e_cmd_op_wait_tile: state_d = st_barrier_tile;
                        // Unknown opcode, drop it
                        default:                        state_d = st_complete;
                    endcase
                end
            end
            // Blocking load, hold until done after the transfer
            st_issue_fetch:     if (i_fetch_ready) state_d = st_wait_fetch_done;
            st_wait_fetch_done: if (i_fetch_done)  state_d = st_complete;
            // Non-blocking, finish on transfer
            st_issue_disp:      if (i_disp_ready)  state_d = st_complete;
            st_issue_tile:      if (i_tile_ready)  state_d = st_complete;
            // Barriers
            st_barrier_disp:    if (i_dc_idle)     state_d = st_complete;
            st_barrier_tile:    if (i_ce_idle)     state_d = st_complete;
            default:                               state_d = st_idle;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (~i_reset_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Request payloads, loaded once per accepted command
    always_ff @(posedge i_clk) begin
        if (frame_xfer) begin
            if (frame_op == mc_cmd_pkg::e_cmd_op_fetch) o_fetch <= fetch_d;
            if (frame_op == mc_cmd_pkg::e_cmd_op_disp)  o_disp  <= disp_d;
            if (frame_op == mc_cmd_pkg::e_cmd_op_tile)  o_tile  <= tile_d;
        end
    end

    // Valids follow the issue states, stable until the handshake
    assign o_fetch_valid = (state_q == st_issue_fetch);
    assign o_disp_valid  = (state_q == st_issue_disp);
    assign o_tile_valid  = (state_q == st_issue_tile);

endmodule

/* design/cmd_frame_reader.sv */
// Command frame reader: packs four stream words into one frame with valid/ready output
module cmd_frame_reader (
    input  logic                                i_clk,
    input  logic                                i_reset_n,

    // Word stream in
    input  logic                                i_cmd_valid,
    input  logic [mc_cmd_pkg::CMD_WORD_W-1:0]   i_cmd_data,
    output logic                                o_cmd_ready,

    // Frame out
    output logic                                o_frame_valid,
    output mc_cmd_pkg::cmd_frame_t              o_frame,
    input  logic                                i_frame_ready
);

    localparam int CNT_W   = $clog2(mc_cmd_pkg::CMD_FRAME_WORDS);
    localparam int FRAME_W = $bits(mc_cmd_pkg::cmd_frame_t);

    logic [CNT_W-1:0]       word_cnt;
    logic                   frame_full;
    logic                   word_xfer;
    logic                   last_word;
    mc_cmd_pkg::cmd_frame_t frame_q;

    // ==============================
    // Stream side
    // ==============================
    // Stream stays open until a complete frame is parked here
    assign o_cmd_ready = ~frame_full;
    assign word_xfer   = i_cmd_valid & o_cmd_ready;
    assign last_word   = (word_cnt == CNT_W'(mc_cmd_pkg::CMD_FRAME_WORDS - 1));

    // Word counter and full flag
    always_ff @(posedge i_clk) begin
        if (~i_reset_n) begin
            word_cnt   <= '0;
            frame_full <= 1'b0;
        end else if (word_xfer) begin
            if (last_word) begin
                word_cnt   <= '0;
                frame_full <= 1'b1;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end else if (frame_full && i_frame_ready) begin
            // Sequencer took the frame, reopen the stream
            frame_full <= 1'b0;
        end
    end

    // Shift from the top so the header ends up in the low word
    always_ff @(posedge i_clk) begin
        if (word_xfer) begin
            frame_q <= {i_cmd_data, frame_q[FRAME_W-1:mc_cmd_pkg::CMD_WORD_W]};
        end
    end

    // ==============================
    // Frame side
    // ==============================
    assign o_frame_valid = frame_full;
    assign o_frame       = frame_q;

endmodule

/* design/mc_engine_pkg.sv */
// Engine side package: field widths and request structs for dispatcher and compute engine
package mc_engine_pkg;

    // Field widths
    localparam int FETCH_ADDR_W = 32;
    localparam int FETCH_LEN_W  = 16;
    localparam int MAX_TILES    = 24;
    localparam int TILE_ADDR_W  = 16;
    localparam int DIM_W        = 8;
    localparam int COL_START_W  = 5;

    // Dispatcher load request
    typedef struct packed {
        logic [FETCH_ADDR_W-1:0] addr;
        logic [FETCH_LEN_W-1:0]  len;
        logic                    right;
    } fetch_req_t;

    // Dispatcher copy into tile memory
    typedef struct packed {
        logic [TILE_ADDR_W-1:0] tile_addr;
        logic [DIM_W-1:0]       count;
        logic [DIM_W-1:0]       vec_size;
        logic                   man_4b;
        logic [MAX_TILES-1:0]   col_en;
        logic [COL_START_W-1:0] col_start;
        logic                   right;
        logic                   broadcast;
    } disp_req_t;

    // Compute engine launch parameters
    typedef struct packed {
        logic [TILE_ADDR_W-1:0] left_addr;
        logic [TILE_ADDR_W-1:0] right_addr;
        logic [DIM_W-1:0]       left_len;
        logic [DIM_W-1:0]       right_len;
        logic [DIM_W-1:0]       vec_len;
        logic                   main_loop_left;
        logic                   right_4b;
        logic                   left_4b;
    } tile_params_t;

    // Full tile request, parameters plus column mask
    typedef struct packed {
        tile_params_t         params;
        logic [MAX_TILES-1:0] col_en;
    } tile_req_t;

endpackage

/* design/mc_cmd_pkg.sv */
// Command format package: opcodes, header, frame struct and payload field layouts
package mc_cmd_pkg;

    // ==============================
    // Stream and frame sizes
    // ==============================
    localparam int CMD_WORD_W        = 32;
    localparam int CMD_FRAME_WORDS   = 4;
    // Header plus three payload words
    localparam int CMD_PAYLOAD_WORDS = CMD_FRAME_WORDS - 1;

    // Opcodes live in header bits 7:0
    typedef enum logic [7:0] {
        e_cmd_op_fetch     = 8'hF0,
        e_cmd_op_disp      = 8'hF1,
        e_cmd_op_tile      = 8'hF2,
        e_cmd_op_wait_disp = 8'hF3,
        e_cmd_op_wait_tile = 8'hF4
    } cmd_op_t;

    // Header word, command id is carried but not acted on
    typedef struct packed {
        logic [15:0] reserved;
        logic [7:0]  cmd_id;
        logic [7:0]  opcode;
    } cmd_header_t;

    // First stream word lands in the low bits
    // Payload index 0 is word 1
    typedef struct packed {
        logic [CMD_PAYLOAD_WORDS-1:0][CMD_WORD_W-1:0] payload;
        cmd_header_t                                  header;
    } cmd_frame_t;

    // ==============================
    // Payload overlays, word 3 at the top
    // ==============================
    typedef struct packed {
        logic [30:0] rsvd3;
        logic        right;
        logic [15:0] rsvd2;
        logic [15:0] len;
        logic [31:0] addr;
    } cmd_fetch_t;

    typedef struct packed {
        logic [23:0] col_en;
        logic [4:0]  col_start;
        logic        right;
        logic        broadcast;
        logic        man_4b;
        logic [15:0] rsvd2;
        logic [15:0] tile_addr;
        logic [7:0]  rsvd1_hi;
        logic [7:0]  count;
        logic [7:0]  rsvd1_lo;
        logic [7:0]  vec_size;
    } cmd_disp_t;

    typedef struct packed {
        logic [23:0] col_en;
        logic [4:0]  rsvd3;
        logic        left_4b;
        logic        right_4b;
        logic        main_loop_left;
        logic [7:0]  rsvd2;
        logic [7:0]  left_len;
        logic [7:0]  right_len;
        logic [7:0]  vec_len;
        logic [15:0] left_addr;
        logic [15:0] right_addr;
    } cmd_tile_t;

endpackage
